// File: hdl/emesh_pkg.sv
package emesh_pkg;

   // packet and address widths
   localparam int PW = 104;
   localparam int AW = 32;

   // packet field positions
   localparam int WR_BIT   = 1;    // write flag
   localparam int CTRL_LSB = 2;    // control/data mode
   localparam int CTRL_MSB = 7;
   localparam int DST_LSB  = 8;    // destination address
   localparam int DST_MSB  = 39;
   localparam int DATA_LSB = 40;   // data
   localparam int DATA_MSB = 71;
   localparam int SRC_LSB  = 72;   // source address
   localparam int SRC_MSB  = 103;

   // link side, msb byte first
   localparam int PKT_BYTES = 13;

   // link identity, upper 12 address bits owned by this link
   localparam logic [11:0] ELINK_ID = 12'h808;

   // column id for the continuity remap
   localparam logic [5:0] COLID = ELINK_ID[5:0];

   // access type as carried in the write flag
   typedef enum logic
   {
      ACC_READ  = 1'b0,
      ACC_WRITE = 1'b1
   } access_t;

endpackage

// File: hdl/erx_cfg_pkg.sv
package erx_cfg_pkg;

   // remap modes, value 2'b11 behaves as dynamic
   typedef enum logic [1:0]
   {
      REMAP_NONE    = 2'b00,
      REMAP_STATIC  = 2'b01,
      REMAP_DYNAMIC = 2'b10
   } remap_mode_t;

   // register map
   localparam logic [3:0] REG_MODE     = 4'd0;
   localparam logic [3:0] REG_SEL      = 4'd1;   // 12 bit
   localparam logic [3:0] REG_PATTERN  = 4'd2;   // 12 bit
   localparam logic [3:0] REG_BASE     = 4'd3;   // 32 bit
   localparam logic [3:0] REG_FWD_CNT  = 4'd4;   // read only, write clears
   localparam logic [3:0] REG_DROP_CNT = 4'd5;   // read only, write clears

   // packet counter width
   localparam int CNT_W = 16;

endpackage

// File: hdl/erx_protocol.sv
`timescale 1ns/100ps

// byte-wide link receiver, builds one mesh packet per 13 framed bytes
module erx_protocol
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       link_frame,
   input  logic [7:0]                 link_data,
   output logic                       rx_access,
   output logic [emesh_pkg::PW-1:0]   rx_packet
);

   typedef logic [$clog2(emesh_pkg::PKT_BYTES)-1:0] cnt_t;

   cnt_t byte_cnt;     // bytes taken so far in the current packet
   logic last_byte;

   // 13th byte of a packet on the link this cycle
   assign last_byte = link_frame && (byte_cnt == cnt_t'(emesh_pkg::PKT_BYTES - 1));

   // byte counter and strobe
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         byte_cnt  <= '0;
         rx_access <= 1'b0;
      end
      else
      begin
         rx_access <= last_byte;
         if (!link_frame)
         begin
            byte_cnt <= '0;            // early frame drop discards partial packet
         end
         else if (last_byte)
         begin
            byte_cnt <= '0;            // frame still high starts next packet
         end
         else
         begin
            byte_cnt <= byte_cnt + 1'b1;
         end
      end
   end

   // shift register, first byte ends up in the top of the packet
   always_ff @(posedge clk)
   begin
      if (link_frame)
      begin
         rx_packet <= {rx_packet[emesh_pkg::PW-9:0], link_data};
      end
   end

   // a packet needs 13 framed bytes, so strobes never come back to back
   // and the frame was up for the whole packet
   a_strobe_spacing: assert property (@(posedge clk) disable iff (reset)
      rx_access |=> !rx_access);

   a_strobe_framed: assert property (@(posedge clk) disable iff (reset)
      rx_access |-> $past(link_frame, 1) && $past(link_frame, emesh_pkg::PKT_BYTES));

endmodule

// File: hdl/erx_remap.sv
`timescale 1ns/100ps

// destination address remap and output register toward the mesh
module erx_remap
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       rx_access,
   input  logic [emesh_pkg::PW-1:0]   rx_packet,
   input  erx_cfg_pkg::remap_mode_t   remap_mode,
   input  logic [11:0]                remap_sel,
   input  logic [11:0]                remap_pattern,
   input  logic [31:0]                remap_base,
   input  logic                       rx_rd_wait,
   input  logic                       rx_wr_wait,
   output logic                       emesh_access_out,
   output logic [emesh_pkg::PW-1:0]   emesh_packet_out,
   output logic                       pkt_fwd,
   output logic                       pkt_drop
);

   typedef logic [emesh_pkg::AW-1:0] addr_t;

   emesh_pkg::access_t in_acc;
   emesh_pkg::access_t held_acc;
   addr_t              addr_in;
   addr_t              static_remap;
   addr_t              dynamic_remap;
   addr_t              addr_out;
   logic               bypass;
   logic               stall;

   assign addr_in  = rx_packet[emesh_pkg::DST_MSB:emesh_pkg::DST_LSB];
   assign in_acc   = emesh_pkg::access_t'(rx_packet[emesh_pkg::WR_BIT]);
   assign held_acc = emesh_pkg::access_t'(emesh_packet_out[emesh_pkg::WR_BIT]);

   // reads and traffic already aimed at this link keep their address
   assign bypass = (in_acc == emesh_pkg::ACC_READ) || (addr_in[31:20] == emesh_pkg::ELINK_ID);

   // static mode takes pattern bits where sel is set
   assign static_remap = {(remap_sel & remap_pattern) | (~remap_sel & addr_in[31:20]),
                          addr_in[19:0]};

   // continuity map collapses the column space onto base
   assign dynamic_remap = addr_in
                          - (addr_t'(emesh_pkg::COLID) << 20)
                          + remap_base
                          - (addr_t'(addr_in[31:26]) << $clog2(emesh_pkg::COLID));

   always_comb
   begin
      if (bypass)
      begin
         addr_out = addr_in;
      end
      else
      begin
         case (remap_mode)
            erx_cfg_pkg::REMAP_NONE:   addr_out = addr_in;
            erx_cfg_pkg::REMAP_STATIC: addr_out = static_remap;
            default:                   addr_out = dynamic_remap;   // 10 and 11
         endcase
      end
   end

   // held packet waits on the wait line of its own type
   assign stall = emesh_access_out &&
                  (((held_acc == emesh_pkg::ACC_WRITE) && rx_wr_wait) ||
                   ((held_acc == emesh_pkg::ACC_READ) && rx_rd_wait));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         emesh_access_out <= 1'b0;
         pkt_fwd          <= 1'b0;
         pkt_drop         <= 1'b0;
      end
      else
      begin
         pkt_fwd  <= rx_access && !stall;
         pkt_drop <= rx_access && stall;   // link cannot be held off
         if (!stall)
         begin
            emesh_access_out <= rx_access;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         emesh_packet_out <= {rx_packet[emesh_pkg::PW-1:emesh_pkg::DST_MSB+1],
                              addr_out,
                              rx_packet[emesh_pkg::DST_LSB-1:0]};
      end
   end

   // a drop is never a forward and never disturbs the held packet
   a_fwd_drop_excl: assert property (@(posedge clk) disable iff (reset)
      pkt_drop |-> !pkt_fwd && emesh_access_out && $stable(emesh_packet_out));

   // frozen output keeps its packet and its access
   a_stall_hold: assert property (@(posedge clk) disable iff (reset)
      emesh_access_out && (emesh_packet_out[emesh_pkg::WR_BIT] ? rx_wr_wait : rx_rd_wait)
      |=> emesh_access_out && $stable(emesh_packet_out));

endmodule

// File: hdl/erx_cfg.sv
`timescale 1ns/100ps

// remap configuration registers and packet counters
module erx_cfg
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       cfg_write,
   input  logic                       cfg_read,
   input  logic [3:0]                 cfg_addr,
   input  logic [31:0]                cfg_wdata,
   output logic [31:0]                cfg_rdata,
   output logic                       cfg_rvalid,
   input  logic                       pkt_fwd,
   input  logic                       pkt_drop,
   output erx_cfg_pkg::remap_mode_t   remap_mode,
   output logic [11:0]                remap_sel,
   output logic [11:0]                remap_pattern,
   output logic [31:0]                remap_base
);

   typedef logic [erx_cfg_pkg::CNT_W-1:0] cnt_t;

   cnt_t fwd_cnt;
   cnt_t drop_cnt;

   // saturating count, a write to the counter clears it
   function automatic cnt_t cnt_next(input cnt_t cnt, input logic inc, input logic clr);
      cnt_t nxt;
      nxt = cnt;
      if (clr)
      begin
         nxt = '0;
      end
      else if (inc && (cnt != '1))
      begin
         nxt = cnt + 1'b1;
      end
      return nxt;
   endfunction

   // register writes
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         remap_mode    <= erx_cfg_pkg::REMAP_NONE;
         remap_sel     <= '0;
         remap_pattern <= '0;
         remap_base    <= '0;
         fwd_cnt       <= '0;
         drop_cnt      <= '0;
      end
      else
      begin
         if (cfg_write)
         begin
            case (cfg_addr)
               erx_cfg_pkg::REG_MODE:    remap_mode    <= erx_cfg_pkg::remap_mode_t'(cfg_wdata[1:0]);
               erx_cfg_pkg::REG_SEL:     remap_sel     <= cfg_wdata[11:0];
               erx_cfg_pkg::REG_PATTERN: remap_pattern <= cfg_wdata[11:0];
               erx_cfg_pkg::REG_BASE:    remap_base    <= cfg_wdata;
               default:                  ;            // counters handled below
            endcase
         end
         fwd_cnt  <= cnt_next(fwd_cnt, pkt_fwd,
                              cfg_write && (cfg_addr == erx_cfg_pkg::REG_FWD_CNT));
         drop_cnt <= cnt_next(drop_cnt, pkt_drop,
                              cfg_write && (cfg_addr == erx_cfg_pkg::REG_DROP_CNT));
      end
   end

   // registered read-back
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cfg_rvalid <= 1'b0;
      end
      else
      begin
         cfg_rvalid <= cfg_read;
      end
   end

   always_ff @(posedge clk)
   begin
      if (cfg_read)
      begin
         case (cfg_addr)
            erx_cfg_pkg::REG_MODE:     cfg_rdata <= {30'b0, remap_mode};
            erx_cfg_pkg::REG_SEL:      cfg_rdata <= {20'b0, remap_sel};
            erx_cfg_pkg::REG_PATTERN:  cfg_rdata <= {20'b0, remap_pattern};
            erx_cfg_pkg::REG_BASE:     cfg_rdata <= remap_base;
            erx_cfg_pkg::REG_FWD_CNT:  cfg_rdata <= {{(32-erx_cfg_pkg::CNT_W){1'b0}}, fwd_cnt};
            erx_cfg_pkg::REG_DROP_CNT: cfg_rdata <= {{(32-erx_cfg_pkg::CNT_W){1'b0}}, drop_cnt};
            default:                   cfg_rdata <= '0;   // unmapped
         endcase
      end
   end

   // one bus access per cycle from the host side
   a_rw_excl: assert property (@(posedge clk) disable iff (reset)
      !(cfg_write && cfg_read));

endmodule

// File: hdl/erx.sv
`timescale 1ns/100ps

// receive slice top, link bytes in, remapped mesh packets out
module erx
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       link_frame,
   input  logic [7:0]                 link_data,
   input  logic                       rx_rd_wait,
   input  logic                       rx_wr_wait,
   output logic                       emesh_access_out,
   output logic [emesh_pkg::PW-1:0]   emesh_packet_out,
   input  logic                       cfg_write,
   input  logic                       cfg_read,
   input  logic [3:0]                 cfg_addr,
   input  logic [31:0]                cfg_wdata,
   output logic [31:0]                cfg_rdata,
   output logic                       cfg_rvalid
);

   logic                       rx_access;
   logic [emesh_pkg::PW-1:0]   rx_packet;
   logic                       pkt_fwd;
   logic                       pkt_drop;
   erx_cfg_pkg::remap_mode_t   remap_mode;
   logic [11:0]                remap_sel;
   logic [11:0]                remap_pattern;
   logic [31:0]                remap_base;

   erx_protocol u_protocol
   (
      .clk        (clk),
      .reset      (reset),
      .link_frame (link_frame),
      .link_data  (link_data),
      .rx_access  (rx_access),
      .rx_packet  (rx_packet)
   );

   erx_remap u_remap
   (
      .clk              (clk),
      .reset            (reset),
      .rx_access        (rx_access),
      .rx_packet        (rx_packet),
      .remap_mode       (remap_mode),
      .remap_sel        (remap_sel),
      .remap_pattern    (remap_pattern),
      .remap_base       (remap_base),
      .rx_rd_wait       (rx_rd_wait),
      .rx_wr_wait       (rx_wr_wait),
      .emesh_access_out (emesh_access_out),
      .emesh_packet_out (emesh_packet_out),
      .pkt_fwd          (pkt_fwd),
      .pkt_drop         (pkt_drop)
   );

   erx_cfg u_cfg
   (
      .clk           (clk),
      .reset         (reset),
      .cfg_write     (cfg_write),
      .cfg_read      (cfg_read),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .cfg_rdata     (cfg_rdata),
      .cfg_rvalid    (cfg_rvalid),
      .pkt_fwd       (pkt_fwd),
      .pkt_drop      (pkt_drop),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base)
   );

endmodule

// File: tb/tb_erx.sv
`timescale 1ns/100ps

module tb_erx;

   localparam int          MAX_CMDS   = 128;
   localparam logic [11:0] LINK_ID    = 12'h808;
   localparam logic [31:0] COL_OFFSET = 32'h0080_0000;   // column id 8 in the top field
   localparam int          COL_SHIFT  = 3;                // ceiling log2 of column id 8
   localparam logic [31:0] NO_DUE     = 32'hffff_ffff;

   typedef struct packed
   {
      logic [emesh_pkg::PW-1:0] pkt;
      logic [31:0]              due;   // cycle the output is due, NO_DUE when held
      logic [15:0]              idx;
   } exp_t;

   logic                     clk;
   logic                     reset;
   logic                     link_frame;
   logic [7:0]               link_data;
   logic                     rx_rd_wait;
   logic                     rx_wr_wait;
   logic                     emesh_access_out;
   logic [emesh_pkg::PW-1:0] emesh_packet_out;
   logic                     cfg_write;
   logic                     cfg_read;
   logic [3:0]               cfg_addr;
   logic [31:0]              cfg_wdata;
   logic [31:0]              cfg_rdata;
   logic                     cfg_rvalid;

   logic [7:0]   cmd_op [MAX_CMDS];
   logic [31:0]  cmd_f0 [MAX_CMDS];
   logic [31:0]  cmd_f1 [MAX_CMDS];
   logic [31:0]  cmd_f2 [MAX_CMDS];
   logic [31:0]  cmd_f3 [MAX_CMDS];
   int           num_cmds    = 0;
   logic         load_done   = 1'b0;
   integer       seed        = 32'he0e1_a425;
   int           error_count = 0;
   int           sent_total  = 0;
   int           deliv_total = 0;
   int           fwd_mark    = 0;   // delivered count at the last counter clear
   int           drop_mark   = 0;
   logic [31:0]  cycle_cnt   = '0;
   exp_t         exp_q [$];

   // model of the remap registers
   logic [1:0]   m_mode    = '0;
   logic [11:0]  m_sel     = '0;
   logic [11:0]  m_pattern = '0;
   logic [31:0]  m_base    = '0;

   erx uut
   (
      .clk              (clk),
      .reset            (reset),
      .link_frame       (link_frame),
      .link_data        (link_data),
      .rx_rd_wait       (rx_rd_wait),
      .rx_wr_wait       (rx_wr_wait),
      .emesh_access_out (emesh_access_out),
      .emesh_packet_out (emesh_packet_out),
      .cfg_write        (cfg_write),
      .cfg_read         (cfg_read),
      .cfg_addr         (cfg_addr),
      .cfg_wdata        (cfg_wdata),
      .cfg_rdata        (cfg_rdata),
      .cfg_rvalid       (cfg_rvalid)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   // sent packets that never showed up and are not outstanding
   function automatic int drops_seen();
      return sent_total - deliv_total - exp_q.size();
   endfunction

   function automatic logic [31:0] expected_address(input logic wr, input logic [31:0] addr);
      logic [31:0] res;
      res = addr;
      if (wr && (addr[31:20] != LINK_ID) && (m_mode != 2'b00))
      begin
         if (m_mode == 2'b01)
         begin
            for (int i = 0; i < 12; i++)
               if (m_sel[i])
                  res[20+i] = m_pattern[i];
         end
         else
            res = addr - COL_OFFSET + m_base - ({26'b0, addr[31:26]} << COL_SHIFT);
      end
      return res;
   endfunction

   task automatic load_vectors(output bit ok);
      int          fd;
      int          r;
      int          c;
      bit          done;
      logic [7:0]  op;
      logic [31:0] f0, f1, f2, f3;
      ok = 1'b0;
      done = 1'b0;
      fd = $fopen("tb/erx_input.txt", "r");
      if (fd != 0)
      begin
         while (!done && (num_cmds < MAX_CMDS))
         begin
            r = $fscanf(fd, " %c", op);
            if (r != 1)
               done = 1'b1;
            else if (op == "#")
            begin
               c = $fgetc(fd);   // skip the rest of a comment line
               while ((c != "\n") && (c != -1))
                  c = $fgetc(fd);
            end
            else
            begin
               f0 = '0;
               f1 = '0;
               f2 = '0;
               f3 = '0;
               case (op)
                  "P":      r = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                  "I", "F": r = $fscanf(fd, "%h", f0);
                  default:  r = $fscanf(fd, "%h %h", f0, f1);
               endcase
               cmd_op[num_cmds] = op;
               cmd_f0[num_cmds] = f0;
               cmd_f1[num_cmds] = f1;
               cmd_f2[num_cmds] = f2;
               cmd_f3[num_cmds] = f3;
               num_cmds++;
            end
         end
         $fclose(fd);
         ok = (num_cmds > 0);
         load_done = ok;
      end
   endtask

   task automatic drive_write(input logic [3:0] addr, input logic [31:0] data);
      @(posedge clk);
      link_frame <= 1'b0;
      cfg_write  <= 1'b1;
      cfg_addr   <= addr;
      cfg_wdata  <= data;
      @(posedge clk);
      cfg_write  <= 1'b0;
      case (addr)
         erx_cfg_pkg::REG_MODE:     m_mode    = data[1:0];
         erx_cfg_pkg::REG_SEL:      m_sel     = data[11:0];
         erx_cfg_pkg::REG_PATTERN:  m_pattern = data[11:0];
         erx_cfg_pkg::REG_BASE:     m_base    = data;
         erx_cfg_pkg::REG_FWD_CNT:  fwd_mark  = deliv_total;
         erx_cfg_pkg::REG_DROP_CNT: drop_mark = drops_seen();
         default:                   ;
      endcase
   endtask

   task automatic read_and_compare(input int idx);
      logic [3:0]  addr;
      logic [31:0] model;
      int          wait_cnt;
      bit          got;
      addr = cmd_f0[idx][3:0];
      case (addr)
         erx_cfg_pkg::REG_MODE:     model = {30'b0, m_mode};
         erx_cfg_pkg::REG_SEL:      model = {20'b0, m_sel};
         erx_cfg_pkg::REG_PATTERN:  model = {20'b0, m_pattern};
         erx_cfg_pkg::REG_BASE:     model = m_base;
         erx_cfg_pkg::REG_FWD_CNT:  model = deliv_total - fwd_mark;
         erx_cfg_pkg::REG_DROP_CNT: model = drops_seen() - drop_mark;
         default:                   model = '0;
      endcase
      if (model != cmd_f1[idx])
      begin
         $display("[FAIL] vec%0d data file value expected %h actual %h", idx, model, cmd_f1[idx]);
         error_count++;
      end
      @(posedge clk);
      link_frame <= 1'b0;
      cfg_read   <= 1'b1;
      cfg_addr   <= addr;
      @(posedge clk);
      cfg_read   <= 1'b0;
      wait_cnt = 0;
      got = 1'b0;
      while (!got && (wait_cnt < 8))
      begin
         @(posedge clk);
         wait_cnt++;
         got = cfg_rvalid;
      end
      if (!got)
      begin
         $display("vec%0d: no read data came back within 8 cycles", idx);
         error_count++;
      end
      else if (cfg_rdata !== cmd_f1[idx])
      begin
         $display("[FAIL] vec%0d read reg %0d expected %h actual %h",
                  idx, addr, cmd_f1[idx], cfg_rdata);
         error_count++;
      end
   endtask

   task automatic send_packet(input int idx);
      logic                     wr;
      logic [31:0]              model;
      logic [31:0]              data;
      logic [31:0]              src;
      logic [7:0]               low;
      logic [emesh_pkg::PW-1:0] pkt;
      exp_t                     e;
      wr = cmd_f0[idx][0];
      model = expected_address(wr, cmd_f1[idx]);
      if (model != cmd_f2[idx])
      begin
         $display("[FAIL] vec%0d data file address expected %h actual %h",
                  idx, model, cmd_f2[idx]);
         error_count++;
      end
      data = $random(seed);
      src = $random(seed);
      low = $random(seed);
      low[1] = wr;
      pkt = {src, data, cmd_f1[idx], low};
      for (int i = 0; i < emesh_pkg::PKT_BYTES; i++)
      begin
         @(posedge clk);
         link_frame <= 1'b1;
         link_data  <= pkt[emesh_pkg::PW-1-8*i -: 8];   // msb byte first
      end
      sent_total++;
      if (cmd_f3[idx] != 0)
      begin
         e.pkt = {src, data, cmd_f2[idx], low};
         e.due = (cmd_f3[idx] == 1) ? cycle_cnt + 3 : NO_DUE;   // sampled two edges later
         e.idx = idx;
         exp_q.push_back(e);
      end
   endtask

   task automatic send_partial_frame(input int n);
      repeat (n)
      begin
         @(posedge clk);
         link_frame <= 1'b1;
         link_data  <= $random(seed);
      end
      @(posedge clk);
      link_frame <= 1'b0;
   endtask

   task automatic hold_idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         link_frame <= 1'b0;
      end
   endtask

   task automatic set_wait_lines(input logic rd, input logic wr);
      @(posedge clk);
      link_frame <= 1'b0;
      rx_rd_wait <= rd;
      rx_wr_wait <= wr;
   endtask

   task automatic run_vectors();
      for (int i = 0; i < num_cmds; i++)
      begin
         case (cmd_op[i])
            "W":     drive_write(cmd_f0[i][3:0], cmd_f1[i]);
            "R":     read_and_compare(i);
            "P":     send_packet(i);
            "S":     set_wait_lines(cmd_f0[i][0], cmd_f1[i][0]);
            "I":     hold_idle(cmd_f0[i]);
            "F":     send_partial_frame(cmd_f0[i]);
            default:
            begin
               $display("vec%0d: unknown command %c in the data file", i, cmd_op[i]);
               error_count++;
            end
         endcase
      end
   endtask

   task automatic drain_output();
      int wait_cnt;
      wait_cnt = 0;
      while ((exp_q.size() != 0) && (wait_cnt < 50))
      begin
         @(posedge clk);
         link_frame <= 1'b0;
         wait_cnt++;
      end
      if (exp_q.size() != 0)
      begin
         $display("%0d expected packets never reached the mesh output", exp_q.size());
         error_count++;
      end
   endtask

   // mesh side, a transfer is taken when access is up and its wait is low
   initial
   begin : monitor
      logic                     stalled;
      logic                     was_stalled;
      logic [emesh_pkg::PW-1:0] snap;
      exp_t                     e;
      was_stalled = 1'b0;
      snap = '0;
      forever
      begin
         @(posedge clk);
         stalled = emesh_access_out && (emesh_packet_out[1] ? rx_wr_wait : rx_rd_wait);
         if (!reset && was_stalled && (!emesh_access_out || (emesh_packet_out !== snap)))
         begin
            $display("[FAIL] stall_hold expected access 1 packet %h actual access %b packet %h",
                     snap, emesh_access_out, emesh_packet_out);
            error_count++;
         end
         if (!reset && emesh_access_out && !stalled)
         begin
            deliv_total++;
            if (exp_q.size() == 0)
            begin
               $display("unexpected packet on the mesh output: %h", emesh_packet_out);
               error_count++;
            end
            else
            begin
               e = exp_q.pop_front();
               if (emesh_packet_out !== e.pkt)
               begin
                  $display("[FAIL] vec%0d packet expected %h actual %h",
                           e.idx, e.pkt, emesh_packet_out);
                  error_count++;
               end
               if ((e.due != NO_DUE) && (cycle_cnt != e.due))
               begin
                  $display("[FAIL] vec%0d arrival cycle expected %0d actual %0d",
                           e.idx, e.due, cycle_cnt);
                  error_count++;
               end
            end
         end
         was_stalled = !reset && stalled;
         snap = emesh_packet_out;
      end
   end

   initial
   begin : watchdog
      int limit;
      wait (load_done);
      limit = num_cmds * 40 + 200;
      repeat (limit) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
   end

   initial
   begin : main
      bit ok;
      reset      = 1'b1;
      link_frame = 1'b0;
      link_data  = '0;
      rx_rd_wait = 1'b0;
      rx_wr_wait = 1'b0;
      cfg_write  = 1'b0;
      cfg_read   = 1'b0;
      cfg_addr   = '0;
      cfg_wdata  = '0;
      load_vectors(ok);
      if (!ok)
      begin
         $display("could not read any command from tb/erx_input.txt");
         $display("Result: FAILED");
         $finish;
      end
      else
      begin
         repeat (5) @(posedge clk);
         reset <= 1'b0;
         run_vectors();
         drain_output();
         $display("delivered %0d, dropped %0d, errors %0d",
                  deliv_total, drops_seen(), error_count);
         if (error_count == 0)
         begin
            $display("Result: PASSED");
         end
         else
         begin
            $display("Result: FAILED");
         end
         $finish;
      end
   end

endmodule

// File: tb/erx_input.txt
# W reg data | R reg expected | S rd_wait wr_wait | I idle_cycles | F partial_bytes (all hex)
# P wr addr expected_addr flag, flag 1 on time, 2 held by a wait, 0 dropped
# mode none
R 0 0
P 1 12345678 12345678 1
P 0 9abcdef0 9abcdef0 1
P 1 80812345 80812345 1
I 4
# static remap
W 0 1
W 1 fff
W 2 abc
R 0 1
R 1 fff
R 2 abc
P 1 12345678 abc45678 1
P 0 12345678 12345678 1
P 1 80800010 80800010 1
W 1 f00
W 2 5a5
P 1 12345678 52345678 1
P 1 deadbeef 5eadbeef 1
W 1 0f0
W 2 a5a
R 1 0f0
P 1 deadbeef d5adbeef 1
P 1 00000000 05000000 1
I 4
# dynamic remap
W 0 2
W 3 00000000
P 1 12345678 11b45658 1
W 3 20000000
R 3 20000000
P 1 12345678 31b45658 1
P 1 40000000 5f7fff80 1
W 3 fff00000
P 1 deadbeef de1dbd37 1
P 0 deadbeef deadbeef 1
P 1 80800000 80800000 1
W 0 3
R 0 3
P 1 12345678 11a45658 1
I 4
W 0 0
R 4 11
R 5 0
# framing
F 5
I 3
P 1 a0000001 a0000001 1
P 1 a0000002 a0000002 1
P 1 a0000003 a0000003 1
F 7
I 2
P 0 a0000004 a0000004 1
I 4
# back-pressure and counters
S 0 1
P 1 11110000 11110000 2
P 1 22220000 22220000 0
P 0 33330000 33330000 0
I 3
S 0 0
S 1 0
P 1 44440000 44440000 1
S 0 0
I 4
R 4 17
R 5 2
W 4 0
W 5 0
R 4 0
R 5 0
P 1 55550000 55550000 1
I 4
R 4 1
R 5 0

// File: sim.f
hdl/emesh_pkg.sv
hdl/erx_cfg_pkg.sv
hdl/erx_protocol.sv
hdl/erx_remap.sv
hdl/erx_cfg.sv
hdl/erx.sv
tb/tb_erx.sv

// File: Bender.yml
package:
  name: erx

sources:
  - hdl/emesh_pkg.sv
  - hdl/erx_cfg_pkg.sv
  - hdl/erx_protocol.sv
  - hdl/erx_remap.sv
  - hdl/erx_cfg.sv
  - hdl/erx.sv
  - target: test
    files:
      - tb/tb_erx.sv
